/* filelist.f */
+incdir+verilog
+incdir+test
verilog/obj_pkg.sv
verilog/obj_if.sv
verilog/obj_ctrl.sv
verilog/obj_line_select.sv
verilog/obj_pri_queue.sv
verilog/obj_tile_fetch.sv
verilog/obj_slice_draw.sv
verilog/obj_line_buffer.sv
verilog/obj_renderer.sv
test/obj_renderer_tb.sv

/* Bender.yml */
package:
  name: obj_renderer

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/obj_pkg.sv
      - verilog/obj_if.sv
      - verilog/obj_ctrl.sv
      - verilog/obj_line_select.sv
      - verilog/obj_pri_queue.sv
      - verilog/obj_tile_fetch.sv
      - verilog/obj_slice_draw.sv
      - verilog/obj_line_buffer.sv
      - verilog/obj_renderer.sv
  - target: test
    include_dirs:
      - verilog
      - test
    files:
      - test/obj_renderer_tb.sv

/* test/obj_model.svh */
/*
  sprite renderer reference model
  paints one line from the sprite RAM image and the graphics table,
  low priority first, then ascending index, last writer wins
*/
`ifndef OBJ_MODEL_SVH
`define OBJ_MODEL_SVH

// expects spr_ram, gfx_rom and model_line in the enclosing testbench

function automatic int wrapped_pos(input logic [8:0] field, input logic [8:0] scroll);
    int p;
    p = (int'(field) + int'(scroll)) % 512;
    if (p > `OBJ_WRAP_LIMIT) p = p - 512;  // far right wraps to negative
    return p;
endfunction

// graphics table word for a tile and byte offset
function automatic int rom_index(input logic [14:0] tile, input int offs);
    return (int'(tile[2:0]) << 7) | ((offs >> 2) & 127);
endfunction

task automatic render_model(input logic [8:0] v, input logic [8:0] sx, input logic [8:0] sy);
    obj_pkg::obj_entry_t e;
    obj_pkg::obj_slice_t sl;
    logic [3:0]          nib;
    int                  ypos;
    int                  xpos;
    int                  row;
    int                  w;
    int                  offs;
    int                  span;
    int                  px;
    for (int i = 0; i < `OBJ_SCREEN_W; i++) model_line[i] = '0;
    for (int p = 0; p < `OBJ_NUM_PRI; p++) begin
        for (int i = 0; i < `OBJ_NUM_SPR; i++) begin
            e    = spr_ram[i];
            ypos = wrapped_pos(e.w3[15:7], sy);
            if (e.w0[15] && int'(e.w0[11:8]) == p && ypos <= int'(v)
                && int'(v) < ypos + 8 * (int'(e.w3[3:0]) + 1)) begin
                row  = int'(v) - ypos;
                w    = int'(e.w2[3:0]) + 1;  // tiles across
                xpos = wrapped_pos(e.w2[15:7], sx);
                for (int c = 0; c < w; c++) begin
                    offs = (row / 8) * w * 32 + (row % 8) * 4 + c * 32;
                    sl   = gfx_rom[rom_index(e.w1[14:0], offs)];
                    for (int k = 0; k < `OBJ_SLICE_PX; k++) begin
                        nib  = sl[4*k +: 4];
                        span = 8 * c + k;
                        px   = e.w0[12] ? xpos + 8 * w - 1 - span : xpos + span;
                        if (nib != 4'd0 && px >= 0 && px < `OBJ_SCREEN_W)
                            model_line[px] = {e.w0[10:8], 2'b00, e.w0[7:2], nib};
                    end
                end
            end
        end
    end
endtask

`endif

/* test/obj_renderer_tb.sv */
/*
  sprite renderer testbench
  models the sprite RAM and a Wishbone graphics ROM with random ack
  delays, renders directed and random lines and compares each readout
  with the reference model
*/
`timescale 1ns/100ps
`include "obj_consts.svh"

module obj_renderer_tb;
    localparam int NUM_LINES      = 58;
    localparam int TIMEOUT_CYCLES = NUM_LINES * 40000;

    logic                CLK96;
    logic                RESET96;
    logic                line_start_i;
    logic [8:0]          vrender_i;
    logic [8:0]          scroll_x_i;
    logic [8:0]          scroll_y_i;
    obj_pkg::spr_idx_t   spr_addr_o;
    obj_pkg::obj_entry_t spr_data_i;
    logic                gfx_cyc_o;
    logic                gfx_stb_o;
    logic [14:0]         gfx_tile_o;
    logic [15:0]         gfx_offs_o;
    obj_pkg::obj_slice_t gfx_dat_i;
    logic                gfx_ack_i;
    logic [8:0]          h_i;
    logic                pixel_cen_i;
    obj_pkg::obj_pixel_t obj_pixel_o;
    logic                render_busy_o;

    obj_pkg::obj_entry_t spr_ram [`OBJ_NUM_SPR];
    obj_pkg::obj_slice_t gfx_rom [1024];
    obj_pkg::obj_pixel_t model_line [`OBJ_SCREEN_W];

    integer seed = 11166;
    int     checks;
    int     pixel_errors;
    int     busy_errors;
    int     lines_done;
    int     cycles;

    `include "obj_model.svh"

    obj_renderer obj_renderer_i (.*);

    initial begin
        CLK96 = 1'b0;
        forever #2 CLK96 = ~CLK96;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge CLK96);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("Test failed");
                $finish;
            end
        end
    end

    function automatic int rand_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    // sprite RAM with data one cycle after the address
    initial begin
        obj_pkg::spr_idx_t addr_d;
        spr_data_i = '0;
        addr_d     = '0;
        forever begin
            @(negedge CLK96);
            spr_data_i = spr_ram[addr_d];
            addr_d     = spr_addr_o;
        end
    end

    // Wishbone slave that acks after 1 to 4 cycles
    initial begin
        int ack_wait;
        gfx_ack_i = 1'b0;
        gfx_dat_i = '0;
        ack_wait  = -1;
        forever begin
            @(negedge CLK96);
            if (gfx_ack_i) begin
                gfx_ack_i = 1'b0;
            end else if (gfx_cyc_o && gfx_stb_o) begin
                if (ack_wait < 0) ack_wait = rand_below(4);
                if (ack_wait == 0) begin
                    gfx_dat_i = gfx_rom[rom_index(gfx_tile_o, int'(gfx_offs_o))];
                    gfx_ack_i = 1'b1;
                end
                ack_wait = ack_wait - 1;
            end
        end
    end

    task automatic check_pixel(input string name, input int h,
                               input obj_pkg::obj_pixel_t expected,
                               input obj_pkg::obj_pixel_t actual);
        checks++;
        if (actual !== expected) begin
            pixel_errors++;
            $display("CHECK FAILED %s line %0d h %0d: expected %h, actual %h",
                     name, lines_done, h, expected, actual);
        end
    endtask

    task automatic check_busy(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            busy_errors++;
            $display("CHECK FAILED %s line %0d: expected %b, actual %b",
                     name, lines_done, expected, actual);
        end
    endtask

    task automatic fill_gfx_rom();
        obj_pkg::obj_slice_t word;
        logic [31:0]         mask;
        for (int i = 0; i < 1024; i++) begin
            word = $random(seed);
            mask = $random(seed);
            for (int k = 0; k < 8; k++) begin
                if (mask[2*k +: 2] == 2'b00) word[4*k +: 4] = 4'd0;  // transparent
            end
            gfx_rom[i] = word;
        end
    endtask

    task automatic clear_ram();
        for (int i = 0; i < `OBJ_NUM_SPR; i++) spr_ram[i] = '0;
    endtask

    task automatic randomize_ram();
        for (int i = 0; i < `OBJ_NUM_SPR; i++) spr_ram[i] = {$random(seed), $random(seed)};
    endtask

    // raw fields with width and height in tiles minus one
    task automatic place_sprite(input int idx, input int x, input int y, input int w,
                                input int h, input int code, input int pri,
                                input int pal, input logic flip);
        obj_pkg::obj_entry_t e;
        e.w0 = {1'b1, 2'b00, flip, 4'(pri), 6'(pal), 2'b00};
        e.w1 = {1'b0, 15'(code)};
        e.w2 = {9'(x), 3'b000, 4'(w)};
        e.w3 = {9'(y), 3'b000, 4'(h)};
        spr_ram[idx] = e;
    endtask

    task automatic wait_idle();
        while (render_busy_o) @(negedge CLK96);
    endtask

    task automatic pulse_line_start();
        line_start_i = 1'b1;
        @(negedge CLK96);
        line_start_i = 1'b0;
    endtask

    // front half read back one cycle after each pixel_cen
    task automatic read_line(input string name);
        for (int h = 0; h <= `OBJ_SCREEN_W; h++) begin
            @(negedge CLK96);
            if (h > 0) check_pixel(name, h - 1, model_line[h-1], obj_pixel_o);
            if (h < `OBJ_SCREEN_W) begin
                h_i         = 9'(h);
                pixel_cen_i = 1'b1;
            end else begin
                pixel_cen_i = 1'b0;
            end
        end
    endtask

    task automatic run_line(input string name, input int v, input int sx, input int sy);
        wait_idle();
        vrender_i  = 9'(v);
        scroll_x_i = 9'(sx);
        scroll_y_i = 9'(sy);
        render_model(9'(v), 9'(sx), 9'(sy));
        pulse_line_start();
        check_busy(name, 1'b1, render_busy_o);
        wait_idle();
        pulse_line_start();  // swap so the rendered half goes to the front
        read_line(name);
        lines_done++;
    endtask

    initial begin
        RESET96      = 1'b1;
        line_start_i = 1'b0;
        vrender_i    = '0;
        scroll_x_i   = '0;
        scroll_y_i   = '0;
        h_i          = '0;
        pixel_cen_i  = 1'b0;
        checks       = 0;
        pixel_errors = 0;
        busy_errors  = 0;
        lines_done   = 0;
        clear_ram();
        fill_gfx_rom();
        repeat (3) @(negedge CLK96);
        RESET96 = 1'b0;

        check_busy("reset_busy", 1'b0, render_busy_o);
        check_busy("reset_gfx_cyc", 1'b0, gfx_cyc_o);
        check_busy("reset_gfx_stb", 1'b0, gfx_stb_o);
        check_pixel("reset_pixel", 0, '0, obj_pixel_o);

        // with an empty RAM the first swap shows the half cleared after reset
        render_model(9'd0, 9'd0, 9'd0);
        pulse_line_start();
        wait_idle();  // the scan outlasts the clear sweep
        read_line("reset_readout");

        // one sprite 3 tiles wide and 2 tall
        place_sprite(5, 40, 20, 2, 1, 'h123, 4, 9, 1'b0);
        run_line("single_top", 22, 0, 0);
        run_line("single_bottom", 30, 0, 0);
        run_line("single_below", 36, 0, 0);

        wait_idle();
        spr_ram[5].w0[12] = 1'b1;
        run_line("xflip", 30, 0, 0);

        wait_idle();
        clear_ram();
        place_sprite(10, 100, 48, 1, 0, 'h011, 3, 1, 1'b0);
        place_sprite(11, 104, 48, 1, 0, 'h012, 3, 2, 1'b0);
        place_sprite(12, 108, 48, 0, 0, 'h013, 5, 3, 1'b1);
        place_sprite(20, 96, 48, 2, 0, 'h014, 2, 4, 1'b0);  // lower level but higher index
        run_line("overlap", 50, 0, 0);

        wait_idle();
        clear_ram();
        place_sprite(1, 500, 10, 3, 1, 'h021, 6, 5, 1'b0);
        place_sprite(2, 300, 10, 3, 1, 'h022, 6, 6, 1'b1);
        place_sprite(3, 374, 10, 0, 0, 'h023, 7, 7, 1'b0);  // lands on 384
        run_line("wrap_clip", 5, 10, 500);
        run_line("wrap_385", 5, 85, 500);

        for (int n = 0; n < 50; n++) begin
            wait_idle();
            randomize_ram();
            run_line("random", rand_below(262), rand_below(512), rand_below(512));
        end

        $display("checks %0d, pixel errors %0d, busy errors %0d",
                 checks, pixel_errors, busy_errors);
        if (pixel_errors + busy_errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* verilog/obj_renderer.sv */
/*
  GP9001-style sprite renderer
  per-line scan, priority queue, Wishbone graphics fetch and
  double line buffer readout
*/
`timescale 1ns/100ps

module obj_renderer (
    input  logic                CLK96,
    input  logic                RESET96,
    input  logic                line_start_i,
    input  logic [8:0]          vrender_i,
    input  logic [8:0]          scroll_x_i,
    input  logic [8:0]          scroll_y_i,
    output obj_pkg::spr_idx_t   spr_addr_o,
    input  obj_pkg::obj_entry_t spr_data_i,
    output logic                gfx_cyc_o,
    output logic                gfx_stb_o,
    output logic [14:0]         gfx_tile_o,
    output logic [15:0]         gfx_offs_o,
    input  obj_pkg::obj_slice_t gfx_dat_i,
    input  logic                gfx_ack_i,
    input  logic [8:0]          h_i,
    input  logic                pixel_cen_i,
    output obj_pkg::obj_pixel_t obj_pixel_o,
    output logic                render_busy_o
);
    logic                hit;
    obj_pkg::obj_attr_t  attr;
    logic                wr_en;
    logic [8:0]          wr_addr;
    obj_pkg::obj_pixel_t wr_pixel;

    obj_queue_if queue_if ();
    obj_fetch_if fetch_if ();

    obj_ctrl obj_ctrl_i (
        .CLK96, .RESET96, .line_start_i, .spr_addr_o,
        .hit_i(hit), .attr_i(attr), .queue(queue_if.ctrl), .fetch(fetch_if.ctrl),
        .render_busy_o
    );

    obj_line_select obj_line_select_i (
        .entry_i(spr_data_i), .vrender_i, .scroll_x_i, .scroll_y_i,
        .hit_o(hit), .attr_o(attr)
    );

    obj_pri_queue obj_pri_queue_i (.CLK96, .RESET96, .queue(queue_if.queue));

    obj_tile_fetch obj_tile_fetch_i (
        .CLK96, .RESET96, .fetch(fetch_if.fetch),
        .gfx_cyc_o, .gfx_stb_o, .gfx_tile_o, .gfx_offs_o, .gfx_dat_i, .gfx_ack_i
    );

    obj_slice_draw obj_slice_draw_i (
        .CLK96, .RESET96, .fetch(fetch_if.draw),
        .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_pixel_o(wr_pixel)
    );

    obj_line_buffer obj_line_buffer_i (
        .CLK96, .RESET96, .line_start_i,
        .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_pixel_i(wr_pixel),
        .h_i, .pixel_cen_i, .obj_pixel_o
    );

endmodule

/* verilog/obj_line_buffer.sv */
/*
  sprite line buffer
  two 320-pixel halves, the back one written by the drawer and the
  front one read out by h and cleared behind the read
*/
`timescale 1ns/100ps
`include "obj_consts.svh"

module obj_line_buffer (
    input  logic                CLK96,
    input  logic                RESET96,
    input  logic                line_start_i,
    input  logic                wr_en_i,
    input  logic [8:0]          wr_addr_i,
    input  obj_pkg::obj_pixel_t wr_pixel_i,
    input  logic [8:0]          h_i,
    input  logic                pixel_cen_i,
    output obj_pkg::obj_pixel_t obj_pixel_o
);
    obj_pkg::obj_pixel_t mem [2][`OBJ_SCREEN_W];
    logic                back;      // half being drawn
    logic [8:0]          clr_addr;  // clearing sweep after reset
    logic                clr_run;
    logic                rd_ok;

    assign clr_run = clr_addr < 9'(`OBJ_SCREEN_W);
    assign rd_ok   = pixel_cen_i && (h_i < 9'(`OBJ_SCREEN_W)) && !clr_run;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            back        <= 1'b0;
            clr_addr    <= '0;
            obj_pixel_o <= '0;
        end else begin
            if (line_start_i) back <= ~back;
            if (clr_run) clr_addr <= clr_addr + 1'b1;
            if (pixel_cen_i) obj_pixel_o <= rd_ok ? mem[~back][h_i] : '0;
        end
    end

    always_ff @(posedge CLK96) begin
        if (clr_run) begin
            mem[0][clr_addr] <= '0;
            mem[1][clr_addr] <= '0;
        end else begin
            if (wr_en_i) mem[back][wr_addr_i] <= wr_pixel_i;
            if (rd_ok) mem[~back][h_i] <= '0;  // clear on read
        end
    end

endmodule

/* verilog/obj_slice_draw.sv */
/*
  sprite slice drawer
  writes the 8 pixels of a slice into the back line buffer, one per
  cycle, skipping transparent nibbles and pixels off screen
*/
`timescale 1ns/100ps
`include "obj_consts.svh"

module obj_slice_draw (
    input  logic               CLK96,
    input  logic               RESET96,
    obj_fetch_if.draw          fetch,
    output logic               wr_en_o,
    output logic [8:0]         wr_addr_o,
    output obj_pkg::obj_pixel_t wr_pixel_o
);
    obj_pkg::obj_slice_t slice_q;
    obj_pkg::obj_attr_t  attr_q;
    logic [3:0]          col_q;
    logic [2:0]          k;  // pixel within slice
    logic [3:0]          nib;
    logic signed [10:0]  xs;
    logic signed [10:0]  span;
    logic signed [10:0]  px;
    logic                take;
    logic                visible;

    assign take = fetch.slice_valid && !fetch.draw_busy;
    assign nib  = slice_q[4*k +: 4];
    assign xs   = {attr_q.x[9], attr_q.x};
    assign span = $signed({4'b0000, col_q, 3'b000}) + $signed({8'd0, k});
    assign px   = attr_q.xflip
                ? xs + $signed({3'b000, {1'b0, attr_q.width} + 5'd1, 3'b000}) - 11'sd1 - span
                : xs + span;
    assign visible = (nib != 4'd0) && (px >= 0) && (px < `OBJ_SCREEN_W);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            fetch.draw_busy <= 1'b0;
            k               <= '0;
            wr_en_o         <= 1'b0;
        end else begin
            wr_en_o <= fetch.draw_busy && visible;
            if (take) begin
                fetch.draw_busy <= 1'b1;
                k               <= '0;
            end else if (fetch.draw_busy) begin
                k <= k + 1'b1;
                if (k == 3'(`OBJ_SLICE_PX - 1)) fetch.draw_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK96) begin
        if (take) begin
            slice_q <= fetch.slice;
            attr_q  <= fetch.attr;  // ctrl may move on to the next sprite
            col_q   <= fetch.col;
        end
        wr_addr_o  <= px[8:0];
        wr_pixel_o <= '{pri: attr_q.pri[2:0], pad: 2'b00, pal: attr_q.pal, color: nib};
    end

endmodule

/* verilog/obj_tile_fetch.sv */
/*
  sprite graphics fetch
  Wishbone classic master reading one 32-bit slice per request,
  the slice is held until the drawer takes it
*/
`timescale 1ns/100ps

module obj_tile_fetch (
    input  logic                CLK96,
    input  logic                RESET96,
    obj_fetch_if.fetch          fetch,
    output logic                gfx_cyc_o,
    output logic                gfx_stb_o,
    output logic [14:0]         gfx_tile_o,
    output logic [15:0]         gfx_offs_o,
    input  obj_pkg::obj_slice_t gfx_dat_i,
    input  logic                gfx_ack_i
);
    logic [15:0] tile_rows;
    logic [15:0] offs;

    // whole tile rows above this line, then row within tile, then column
    assign tile_rows = 16'(fetch.attr.row[6:3]) * (16'(fetch.attr.width) + 16'd1);
    assign offs = (tile_rows << 5) + 16'({fetch.attr.row[2:0], 2'b00})
                + 16'({fetch.col, 5'b00000});

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            gfx_cyc_o         <= 1'b0;
            gfx_stb_o         <= 1'b0;
            gfx_tile_o        <= '0;
            gfx_offs_o        <= '0;
            fetch.slice_valid <= 1'b0;
        end else begin
            if (fetch.slice_valid && !fetch.draw_busy) fetch.slice_valid <= 1'b0;
            if (gfx_cyc_o) begin
                if (gfx_ack_i) begin
                    gfx_cyc_o         <= 1'b0;
                    gfx_stb_o         <= 1'b0;
                    fetch.slice_valid <= 1'b1;
                end
            end else if (fetch.req) begin
                gfx_cyc_o  <= 1'b1;
                gfx_stb_o  <= 1'b1;
                gfx_tile_o <= fetch.attr.code;
                gfx_offs_o <= offs;
            end
        end
    end

    always_ff @(posedge CLK96) begin
        if (gfx_cyc_o && gfx_ack_i) fetch.slice <= gfx_dat_i;  // captured on ack
    end

    a_addr_stable: assert property (@(posedge CLK96) disable iff (RESET96)
        gfx_stb_o && !gfx_ack_i |=> gfx_stb_o && $stable(gfx_tile_o) && $stable(gfx_offs_o));

endmodule

/* verilog/obj_pri_queue.sv */
/*
  sprite priority queue
  keeps the hit indices of each priority level in push order and
  points the walk at the lowest level still waiting
*/
`timescale 1ns/100ps
`include "obj_consts.svh"

module obj_pri_queue (
    input logic        CLK96,
    input logic        RESET96,
    obj_queue_if.queue queue
);
    obj_pkg::spr_cnt_t           cnt [`OBJ_NUM_PRI];
    logic [`OBJ_NUM_PRI-1:0]     pending;  // levels with entries, not yet walked
    obj_pkg::spr_idx_t           idx_mem [`OBJ_NUM_PRI * `OBJ_NUM_SPR];

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            for (int p = 0; p < `OBJ_NUM_PRI; p++) cnt[p] <= '0;
            pending <= '0;
        end else if (queue.clear) begin
            for (int p = 0; p < `OBJ_NUM_PRI; p++) cnt[p] <= '0;
            pending <= '0;
        end else begin
            if (queue.push) begin
                cnt[queue.push_pri]     <= cnt[queue.push_pri] + 1'b1;
                pending[queue.push_pri] <= 1'b1;
            end
            if (queue.pri_take) pending[queue.next_pri] <= 1'b0;
        end
    end

    // index storage, level in the upper address bits
    always_ff @(posedge CLK96) begin
        if (queue.push) idx_mem[{queue.push_pri, cnt[queue.push_pri][7:0]}] <= queue.push_idx;
        queue.rd_idx <= idx_mem[{queue.rd_pri, queue.rd_pos}];
    end

    always_comb begin
        queue.next_pri = '0;
        for (int p = `OBJ_NUM_PRI - 1; p >= 0; p--) begin
            if (pending[p]) queue.next_pri = obj_pkg::pri_t'(p);  // lowest wins
        end
    end

    assign queue.none_left = ~|pending;
    assign queue.rd_cnt    = cnt[queue.rd_pri];

    a_no_overflow: assert property (@(posedge CLK96) disable iff (RESET96)
        queue.push |-> cnt[queue.push_pri] != `OBJ_NUM_SPR);

endmodule

/* verilog/obj_line_select.sv */
/*
  sprite line select
  decodes one sprite entry, applies scroll and wrap, and tells whether
  the sprite crosses the line being rendered
*/
`timescale 1ns/100ps
`include "obj_consts.svh"

module obj_line_select (
    input  obj_pkg::obj_entry_t entry_i,
    input  logic [8:0]          vrender_i,
    input  logic [8:0]          scroll_x_i,
    input  logic [8:0]          scroll_y_i,
    output logic                hit_o,
    output obj_pkg::obj_attr_t  attr_o
);
    logic [8:0]         xpos_mod;
    logic [8:0]         ypos_mod;
    logic signed [10:0] xpos;
    logic signed [10:0] ypos;
    logic signed [10:0] vpos;
    logic signed [10:0] ybottom;
    logic signed [10:0] row;

    function automatic logic signed [10:0] wrap_pos(input logic [8:0] p);
        if (p > `OBJ_WRAP_LIMIT) return $signed({2'b00, p}) - 11'sd512;
        return $signed({2'b00, p});
    endfunction

    assign xpos_mod = entry_i.w2[`OBJ_POS_MSB:`OBJ_POS_LSB] + scroll_x_i;  // mod 512
    assign ypos_mod = entry_i.w3[`OBJ_POS_MSB:`OBJ_POS_LSB] + scroll_y_i;
    assign xpos     = wrap_pos(xpos_mod);
    assign ypos     = wrap_pos(ypos_mod);
    assign vpos     = $signed({2'b00, vrender_i});
    assign ybottom  = ypos + $signed({3'b000, {1'b0, entry_i.w3[3:0]} + 5'd1, 3'b000});
    assign row      = vpos - ypos;

    assign hit_o = entry_i.w0[`OBJ_ACTIVE_BIT] && (ypos <= vpos) && (vpos < ybottom);

    assign attr_o.x     = xpos[9:0];
    assign attr_o.row   = row[6:0];
    assign attr_o.width = entry_i.w2[3:0];
    assign attr_o.xflip = entry_i.w0[`OBJ_XFLIP_BIT];
    assign attr_o.pal   = entry_i.w0[7:2];
    assign attr_o.pri   = entry_i.w0[11:8];
    assign attr_o.code  = entry_i.w1[14:0];

endmodule

/* verilog/obj_ctrl.sv */
/*
  sprite renderer control FSM
  scans all entries for the line and queues the hits, then walks the
  priorities from low to high, re-reads each queued entry and requests
  one graphics slice per tile column
*/
`timescale 1ns/100ps
`include "obj_consts.svh"

module obj_ctrl (
    input  logic               CLK96,
    input  logic               RESET96,
    input  logic               line_start_i,
    output obj_pkg::spr_idx_t  spr_addr_o,
    input  logic               hit_i,
    input  obj_pkg::obj_attr_t attr_i,
    obj_queue_if.ctrl          queue,
    obj_fetch_if.ctrl          fetch,
    output logic               render_busy_o
);
    obj_pkg::ctrl_state_t state;
    obj_pkg::spr_idx_t    cur_idx;  // entry being addressed
    obj_pkg::spr_cnt_t    pos;      // position within current level
    obj_pkg::obj_attr_t   attr_q;
    logic [3:0]           col;
    logic                 take;

    assign take = fetch.slice_valid && !fetch.draw_busy;  // drawer accepts a slice

    assign spr_addr_o     = cur_idx;
    assign queue.clear    = (state == obj_pkg::S_IDLE) && line_start_i;
    assign queue.push     = (state == obj_pkg::S_CHK) && hit_i;
    assign queue.push_pri = attr_i.pri;
    assign queue.push_idx = cur_idx;
    assign queue.pri_take = (state == obj_pkg::S_PRI) && !queue.none_left;
    assign queue.rd_pos   = pos[7:0];

    assign fetch.req  = (state == obj_pkg::S_REQ);
    assign fetch.attr = attr_q;
    assign fetch.col  = col;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state         <= obj_pkg::S_IDLE;
            render_busy_o <= 1'b0;
            cur_idx       <= '0;
            pos           <= '0;
            col           <= '0;
            queue.rd_pri  <= '0;
        end else begin
            case (state)
                obj_pkg::S_IDLE: if (line_start_i) begin
                    render_busy_o <= 1'b1;
                    cur_idx       <= '0;
                    state         <= obj_pkg::S_SCAN;
                end
                obj_pkg::S_SCAN: state <= obj_pkg::S_CHK;  // entry data arrives
                obj_pkg::S_CHK: begin
                    if (cur_idx == 8'(`OBJ_NUM_SPR - 1)) begin
                        state <= obj_pkg::S_PRI;
                    end else begin
                        cur_idx <= cur_idx + 1'b1;
                        state   <= obj_pkg::S_SCAN;
                    end
                end
                obj_pkg::S_PRI: begin
                    if (queue.none_left) begin
                        state <= obj_pkg::S_DONE;
                    end else begin
                        queue.rd_pri <= queue.next_pri;
                        pos          <= '0;
                        state        <= obj_pkg::S_LVL;
                    end
                end
                obj_pkg::S_LVL: state <= (pos == queue.rd_cnt) ? obj_pkg::S_PRI : obj_pkg::S_IDX;
                obj_pkg::S_IDX: begin
                    cur_idx <= queue.rd_idx;  // re-read the queued entry
                    state   <= obj_pkg::S_ENT;
                end
                obj_pkg::S_ENT: state <= obj_pkg::S_ATTR;
                obj_pkg::S_ATTR: begin
                    col   <= '0;
                    state <= obj_pkg::S_REQ;
                end
                obj_pkg::S_REQ: state <= obj_pkg::S_WAIT;
                obj_pkg::S_WAIT: if (take) begin
                    if (col == attr_q.width) begin
                        pos   <= pos + 1'b1;
                        state <= obj_pkg::S_LVL;
                    end else begin
                        col   <= col + 1'b1;  // next fetch overlaps this draw
                        state <= obj_pkg::S_REQ;
                    end
                end
                obj_pkg::S_DONE: if (!fetch.draw_busy) begin
                    render_busy_o <= 1'b0;
                    state         <= obj_pkg::S_IDLE;
                end
                default: state <= obj_pkg::S_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK96) begin
        if (state == obj_pkg::S_ATTR) attr_q <= attr_i;
    end

    // a requested slice stays covered by busy until the drawer accepts it
    a_busy_fetch: assert property (@(posedge CLK96) disable iff (RESET96)
        fetch.req |-> render_busy_o until_with (fetch.slice_valid && !fetch.draw_busy));

endmodule

/* verilog/obj_if.sv */
/*
  sprite renderer interfaces
  obj_queue_if links the control FSM to the priority queue,
  obj_fetch_if links it to the graphics fetch and the slice drawer
*/
`timescale 1ns/100ps

interface obj_queue_if;
    logic              clear;
    logic              push;
    obj_pkg::pri_t     push_pri;
    obj_pkg::spr_idx_t push_idx;
    logic              pri_take;  // marks next_pri as walked
    obj_pkg::pri_t     rd_pri;
    obj_pkg::spr_idx_t rd_pos;
    obj_pkg::spr_idx_t rd_idx;
    obj_pkg::spr_cnt_t rd_cnt;
    obj_pkg::pri_t     next_pri;
    logic              none_left;

    modport ctrl (output clear, push, push_pri, push_idx, pri_take, rd_pri, rd_pos,
                  input rd_idx, rd_cnt, next_pri, none_left);
    modport queue (input clear, push, push_pri, push_idx, pri_take, rd_pri, rd_pos,
                   output rd_idx, rd_cnt, next_pri, none_left);
endinterface

interface obj_fetch_if;
    logic                req;
    obj_pkg::obj_attr_t  attr;
    logic [3:0]          col;
    obj_pkg::obj_slice_t slice;
    logic                slice_valid;
    logic                draw_busy;

    modport ctrl (output req, attr, col, input slice_valid, draw_busy);
    modport fetch (input req, attr, col, draw_busy, output slice, slice_valid);
    modport draw (input slice, slice_valid, attr, col, output draw_busy);
endinterface

/* verilog/obj_pkg.sv */
/*
  sprite renderer types
  raw and decoded sprite entries, line buffer pixels, slices,
  queue indices and the control FSM states
*/
package obj_pkg;

    typedef logic [7:0] spr_idx_t;
    typedef logic [8:0] spr_cnt_t;  // 0 to 256 entries per level
    typedef logic [3:0] pri_t;
    typedef logic [31:0] obj_slice_t;  // pixel k in nibble k

    // word 0 holds flags, word 1 the tile code, words 2 and 3 x and y
    typedef struct packed {
        logic [15:0] w0;
        logic [15:0] w1;
        logic [15:0] w2;
        logic [15:0] w3;
    } obj_entry_t;

    typedef struct packed {
        logic signed [9:0] x;
        logic [6:0]        row;    // line within the sprite
        logic [3:0]        width;  // tiles minus one
        logic              xflip;
        logic [5:0]        pal;
        pri_t              pri;
        logic [14:0]       code;
    } obj_attr_t;

    typedef struct packed {
        logic [2:0] pri;
        logic [1:0] pad;
        logic [5:0] pal;
        logic [3:0] color;
    } obj_pixel_t;

    typedef enum logic [3:0] {
        S_IDLE, S_SCAN, S_CHK, S_PRI, S_LVL, S_IDX, S_ENT, S_ATTR, S_REQ, S_WAIT, S_DONE
    } ctrl_state_t;

endpackage

/* verilog/obj_consts.svh */
/*
  sprite renderer constants
  screen geometry, table sizes and sprite entry field positions
*/
`ifndef OBJ_CONSTS_SVH
`define OBJ_CONSTS_SVH

`define OBJ_SCREEN_W   320   // visible pixels per line
`define OBJ_NUM_SPR    256   // sprite attribute entries
`define OBJ_NUM_PRI    16    // priority levels
`define OBJ_WRAP_LIMIT 384   // positions above this wrap negative
`define OBJ_SLICE_PX   8     // pixels per 32-bit graphics slice

// field positions inside the 16-bit entry words
`define OBJ_ACTIVE_BIT 15
`define OBJ_XFLIP_BIT  12
`define OBJ_POS_MSB    15
`define OBJ_POS_LSB    7

`endif
